// ==== src/sorter_pkg.sv ====
// Shared constants, chunk control struct, serializer states and Batcher comparator map
`default_nettype none

package sorter_pkg;

    // Words per chunk and depth of the odd-even merge network for that size
    localparam int lanes = 8;
    localparam int num_layers = 6;

    // Chunk length, 1 to 8
    typedef logic [3:0] count_t;

    // Control that travels beside each chunk through the network
    typedef struct packed {
        logic   valid;
        count_t count;
    } chunk_ctrl_t;

    typedef enum logic {
        state_idle,
        state_emit
    } ser_state_t;

    // Returns the partner lane of a lane in one layer of the 8-input odd-even merge network.
    // A lane without a comparator in that layer returns itself.
    // The lower lane of each pair keeps the smaller value
    function automatic logic [2:0] batcher_partner(input int layer, input int lane,
                                                   output logic keep_min);
        int p;
        p = lane;
        case (layer)
            0: p = lane ^ 1;
            1: p = lane ^ 2;
            2: begin
                if (lane % 4 == 1) p = lane + 1;
                else if (lane % 4 == 2) p = lane - 1;
            end
            3: p = lane ^ 4;
            4: begin
                if (lane == 2 || lane == 3) p = lane + 2;
                else if (lane == 4 || lane == 5) p = lane - 2;
            end
            5: begin
                if (lane >= 1 && lane <= 6) p = (lane % 2 == 1) ? lane + 1 : lane - 1;
            end
            default: p = lane;
        endcase
        keep_min = (p > lane);
        return 3'(p);
    endfunction

endpackage

`default_nettype wire

// ==== src/chunk_collector.sv ====
// Double-buffered serial-to-parallel collector that zero-pads short chunks and launches them
`timescale 1ns/10ps
`default_nettype none

module chunk_collector #(
    parameter int DATA_WIDTH = 16
) (
    input  wire logic                                             clock,
    input  wire logic                                             rst,
    input  wire logic                                             advance,
    input  wire sorter_pkg::count_t                               chunk_size,
    input  wire logic [DATA_WIDTH-1:0]                            in_data,
    input  wire logic                                             in_valid,
    output logic [sorter_pkg::lanes-1:0][DATA_WIDTH-1:0]          chunk_data,
    output sorter_pkg::chunk_ctrl_t                               chunk_ctrl
);

    // Two chunk buffers, one being filled while the other is presented
    logic [1:0][sorter_pkg::lanes-1:0][DATA_WIDTH-1:0] buffers;
    logic                                              fill_sel;
    logic [2:0]                                        fill_index;
    sorter_pkg::count_t                                chunk_len;
    sorter_pkg::chunk_ctrl_t                           launch_ctrl;

    sorter_pkg::count_t cur_len;
    logic               last_word;

    // The length is taken from the port on the first word of a chunk
    assign cur_len   = (fill_index == 3'd0) ? chunk_size : chunk_len;
    assign last_word = ({1'b0, fill_index} == cur_len - 4'd1);

    always_ff @(posedge clock) begin
        if (rst) begin
            buffers     <= '0;
            fill_sel    <= 1'b0;
            fill_index  <= 3'd0;
            chunk_len   <= 4'd0;
            launch_ctrl <= '0;
        end else if (advance) begin
            // A word only moves when the whole pipeline moves
            // Presented chunk is taken by layer 0 on this edge unless a new one replaces it
            launch_ctrl.valid <= 1'b0;
            if (in_valid) begin
                buffers[fill_sel][fill_index] <= in_data;
                if (fill_index == 3'd0) begin
                    chunk_len <= chunk_size;
                end
                if (last_word) begin
                    fill_index <= 3'd0;
                    fill_sel   <= ~fill_sel;
                    // The old presented buffer becomes the fill buffer and starts as padding
                    buffers[~fill_sel] <= '0;
                    launch_ctrl.valid  <= 1'b1;
                    launch_ctrl.count  <= cur_len;
                end else begin
                    fill_index <= fill_index + 3'd1;
                end
            end
        end
    end

    assign chunk_data = buffers[~fill_sel];
    assign chunk_ctrl = launch_ctrl;

endmodule

`default_nettype wire

// ==== src/merge_layer.sv ====
// One registered compare-exchange layer of the 8-lane Batcher odd-even merge network
`timescale 1ns/10ps
`default_nettype none

module merge_layer #(
    parameter int DATA_WIDTH = 16,
    parameter int LAYER = 0
) (
    input  wire logic                                             clock,
    input  wire logic                                             rst,
    input  wire logic                                             advance,
    input  wire logic [sorter_pkg::lanes-1:0][DATA_WIDTH-1:0]     in_data,
    input  wire sorter_pkg::chunk_ctrl_t                          in_ctrl,
    output logic [sorter_pkg::lanes-1:0][DATA_WIDTH-1:0]          out_data,
    output sorter_pkg::chunk_ctrl_t                               out_ctrl
);

    logic [sorter_pkg::lanes-1:0][DATA_WIDTH-1:0] exchanged;

    // Each lane looks up its partner and keeps either the smaller or the larger of the pair
    always_comb begin
        logic [2:0]            partner;
        logic                  keep_min;
        logic [DATA_WIDTH-1:0] own;
        logic [DATA_WIDTH-1:0] other;
        for (int i = 0; i < sorter_pkg::lanes; i++) begin
            partner = sorter_pkg::batcher_partner(LAYER, i, keep_min);
            own     = in_data[i];
            other   = in_data[partner];
            if (int'(partner) == i) begin
                // No comparator on this lane in this layer
                exchanged[i] = own;
            end else if (keep_min) begin
                exchanged[i] = (other < own) ? other : own;
            end else begin
                exchanged[i] = (other > own) ? other : own;
            end
        end
    end

    // Chunk control moves one layer on each enabled edge, in step with the data
    always_ff @(posedge clock) begin
        if (rst) begin
            out_ctrl <= '0;
        end else if (advance) begin
            out_ctrl <= in_ctrl;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            out_data <= exchanged;
        end
    end

endmodule

`default_nettype wire

// ==== src/sorted_serializer.sv ====
// Holds one sorted chunk and emits its real words in ascending order with a last marker
`timescale 1ns/10ps
`default_nettype none

module sorted_serializer #(
    parameter int DATA_WIDTH = 16
) (
    input  wire logic                                             clock,
    input  wire logic                                             rst,
    input  wire logic [sorter_pkg::lanes-1:0][DATA_WIDTH-1:0]     in_data,
    input  wire sorter_pkg::chunk_ctrl_t                          in_ctrl,
    input  wire logic                                             out_ready,
    output logic                                                  advance,
    output logic [DATA_WIDTH-1:0]                                 out_data,
    output logic                                                  out_valid,
    output logic                                                  out_last
);

    sorter_pkg::ser_state_t                       state;
    logic [sorter_pkg::lanes-1:0][DATA_WIDTH-1:0] hold_data;
    logic [2:0]                                   read_index;
    logic [2:0]                                   start_index;

    // Padding zeros sit in the low lanes, so the real words start at lanes minus count
    assign start_index = 3'(sorter_pkg::lanes - int'(in_ctrl.count));

    assign out_valid = (state == sorter_pkg::state_emit);
    assign out_last  = out_valid && (read_index == 3'(sorter_pkg::lanes - 1));
    assign out_data  = hold_data[read_index];

    // A new chunk can enter when idle or when the final word leaves on this edge
    assign advance = (state == sorter_pkg::state_idle) || (out_last && out_ready);

    always_ff @(posedge clock) begin
        if (rst) begin
            state      <= sorter_pkg::state_idle;
            read_index <= 3'd0;
        end else begin
            case (state)
                sorter_pkg::state_idle: begin
                    if (in_ctrl.valid) begin
                        state      <= sorter_pkg::state_emit;
                        read_index <= start_index;
                    end
                end
                sorter_pkg::state_emit: begin
                    if (out_ready) begin
                        if (out_last) begin
                            // Take the next chunk straight away if layer 5 has one
                            if (in_ctrl.valid) begin
                                read_index <= start_index;
                            end else begin
                                state <= sorter_pkg::state_idle;
                            end
                        end else begin
                            read_index <= read_index + 3'd1;
                        end
                    end
                end
                default: state <= sorter_pkg::state_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (advance && in_ctrl.valid) begin
            hold_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/batcher_sort_top.sv ====
// Serial chunk sorter joining the collector, the six-layer Batcher network and the serializer
`timescale 1ns/10ps
`default_nettype none

module batcher_sort_top #(
    parameter int DATA_WIDTH = 16
) (
    input  wire logic                    clock,
    input  wire logic                    rst,
    input  wire sorter_pkg::count_t      chunk_size,
    input  wire logic [DATA_WIDTH-1:0]   in_data,
    input  wire logic                    in_valid,
    input  wire logic                    out_ready,
    output logic                         in_ready,
    output logic [DATA_WIDTH-1:0]        out_data,
    output logic                         out_valid,
    output logic                         out_last
);

    // Stage 0 is the collector output, stage k+1 the output of layer k
    logic [sorter_pkg::num_layers:0][sorter_pkg::lanes-1:0][DATA_WIDTH-1:0] stage_data;
    sorter_pkg::chunk_ctrl_t [sorter_pkg::num_layers:0]                     stage_ctrl;
    logic                                                                   advance;

    assign in_ready = advance;

    chunk_collector #(
        .DATA_WIDTH(DATA_WIDTH)
    ) collector (
        .clock     (clock),
        .rst       (rst),
        .advance   (advance),
        .chunk_size(chunk_size),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .chunk_data(stage_data[0]),
        .chunk_ctrl(stage_ctrl[0])
    );

    for (genvar k = 0; k < sorter_pkg::num_layers; k++) begin : g_layer
        merge_layer #(
            .DATA_WIDTH(DATA_WIDTH),
            .LAYER     (k)
        ) layer (
            .clock   (clock),
            .rst     (rst),
            .advance (advance),
            .in_data (stage_data[k]),
            .in_ctrl (stage_ctrl[k]),
            .out_data(stage_data[k+1]),
            .out_ctrl(stage_ctrl[k+1])
        );
    end

    sorted_serializer #(
        .DATA_WIDTH(DATA_WIDTH)
    ) serializer (
        .clock    (clock),
        .rst      (rst),
        .in_data  (stage_data[sorter_pkg::num_layers]),
        .in_ctrl  (stage_ctrl[sorter_pkg::num_layers]),
        .out_ready(out_ready),
        .advance  (advance),
        .out_data (out_data),
        .out_valid(out_valid),
        .out_last (out_last)
    );

endmodule

`default_nettype wire

// ==== tests/batcher_sort_assertions.sv ====
// Concurrent protocol checks on the sorter ports, bound to the top level
`timescale 1ns/10ps
`default_nettype none

module batcher_sort_assertions #(
    parameter int DATA_WIDTH = 16
) (
    input wire logic                  clock,
    input wire logic                  rst,
    input wire logic                  in_ready,
    input wire logic                  out_ready,
    input wire logic [DATA_WIDTH-1:0] out_data,
    input wire logic                  out_valid,
    input wire logic                  out_last
);

    // Reset leaves the serializer idle
    reset_idle: assert property (@(posedge clock) rst |=> !out_valid && !out_last)
        else $error("out_valid or out_last high after reset");

    // A stalled word stays on the bus unchanged
    stall_hold: assert property (@(posedge clock) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else $error("output changed while stalled");

    // Input is taken only when the serializer can take the next chunk
    ready_match: assert property (@(posedge clock) disable iff (rst)
        in_ready == (!out_valid || (out_last && out_ready)))
        else $error("in_ready does not follow the serializer state");

    last_valid: assert property (@(posedge clock) disable iff (rst) out_last |-> out_valid)
        else $error("out_last without out_valid");

endmodule

bind batcher_sort_top batcher_sort_assertions #(
    .DATA_WIDTH(DATA_WIDTH)
) protocol_checks (
    .clock    (clock),
    .rst      (rst),
    .in_ready (in_ready),
    .out_ready(out_ready),
    .out_data (out_data),
    .out_valid(out_valid),
    .out_last (out_last)
);

`default_nettype wire

// ==== tests/batcher_sort_tb.sv ====
// Testbench for the serial chunk sorter, driven from a pattern file with random gaps and stalls
`timescale 1ns/10ps
`default_nettype none

module batcher_sort_tb;

    localparam int DATA_WIDTH = 16;
    localparam int MEM_DEPTH = 1024;
    localparam int WAIT_LIMIT = 2000;
    // The first records go through back to back before gaps and stalls begin
    localparam int GAP_FROM_RECORD = 12;
    localparam int STALL_FROM_WORD = 40;
    localparam int DRAIN_CYCLES = 20;

    logic                  clock;
    logic                  rst;
    sorter_pkg::count_t    chunk_size;
    logic [DATA_WIDTH-1:0] in_data;
    logic                  in_valid;
    logic                  out_ready = 1'b0;
    logic                  in_ready;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  out_valid;
    logic                  out_last;

    // Pattern memory holds records of length, input words and sorted words
    logic [DATA_WIDTH-1:0] patterns [MEM_DEPTH];
    logic [DATA_WIDTH-1:0] expected_words [$];
    logic                  expected_last [$];
    int                    words_seen = 0;
    logic [31:0]           in_rng;
    logic [31:0]           out_rng = 32'hf2c4;

    batcher_sort_top #(
        .DATA_WIDTH(DATA_WIDTH)
    ) uut (
        .clock     (clock),
        .rst       (rst),
        .chunk_size(chunk_size),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    always #5 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s is %h, expected %h", $time, name, actual, expected);
            abort_run("a DUT output did not match its expected value");
        end
    endtask

    // Drives one word and returns once in_ready shows it will be taken on the next edge
    task automatic send_word(input int len, input logic [DATA_WIDTH-1:0] word,
                             input logic gaps_on);
        int waited;
        in_rng = xorshift32(in_rng);
        if (gaps_on && in_rng[2:0] == 3'd0) begin
            @(posedge clock);
            in_valid <= 1'b0;
        end
        @(posedge clock);
        in_valid   <= 1'b1;
        in_data    <= word;
        chunk_size <= 4'(len);
        waited = 0;
        @(negedge clock);
        while (!in_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("an input word was not accepted before the wait limit");
            end
            @(negedge clock);
        end
    endtask

    // Random output stalls once enough words have passed without them
    always @(posedge clock) begin
        if (rst) begin
            out_ready <= 1'b0;
        end else begin
            out_rng = xorshift32(out_rng);
            if (words_seen >= STALL_FROM_WORD) begin
                out_ready <= (out_rng[1:0] != 2'b00);
            end else begin
                out_ready <= 1'b1;
            end
        end
    end

    // Output words are checked at the falling edge, where the handshake is stable
    always @(negedge clock) begin
        logic [DATA_WIDTH-1:0] want_word;
        logic                  want_last;
        if (!rst && out_valid && out_ready) begin
            if (expected_words.size() == 0) begin
                abort_run("the DUT emitted a word when no word was expected");
            end else begin
                want_word = expected_words.pop_front();
                want_last = expected_last.pop_front();
                check_value("out_data", 32'(out_data), 32'(want_word));
                check_value("out_last", 32'(out_last), 32'(want_last));
                words_seen = words_seen + 1;
            end
        end
    end

    initial begin
        int ptr;
        int len;
        int record;
        int waited;
        clock      = 1'b0;
        rst        = 1'b1;
        chunk_size = '0;
        in_data    = '0;
        in_valid   = 1'b0;
        in_rng     = xorshift32(xorshift32(32'hf2c4));
        $readmemh("tests/sort_patterns.txt", patterns);

        repeat (16) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("out_last", 32'(out_last), 32'd0);
        check_value("in_ready", 32'(in_ready), 32'd1);

        ptr    = 0;
        record = 0;
        while (ptr < MEM_DEPTH && patterns[ptr] != 16'd0) begin
            len = int'(patterns[ptr]);
            if (len > sorter_pkg::lanes || ptr + 2 * len >= MEM_DEPTH) begin
                abort_run("the patterns file holds a record that cannot be a chunk");
            end
            for (int i = 0; i < len; i++) begin
                expected_words.push_back(patterns[ptr + 1 + len + i]);
                expected_last.push_back(i == len - 1);
            end
            for (int i = 0; i < len; i++) begin
                send_word(len, patterns[ptr + 1 + i], record >= GAP_FROM_RECORD);
            end
            ptr    = ptr + 1 + 2 * len;
            record = record + 1;
        end
        @(posedge clock);
        in_valid <= 1'b0;

        waited = 0;
        while (expected_words.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("not every expected word came out before the wait limit");
            end
            @(posedge clock);
        end

        // Nothing more may come out once the last chunk has left
        repeat (DRAIN_CYCLES) @(posedge clock);
        @(negedge clock);
        check_value("out_valid", 32'(out_valid), 32'd0);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/sort_patterns.txt ====
// Each record: chunk length, then that many input words, then the same count of sorted words
// A length of zero ends the list
0008 0005 0003 0007 0001 0008 0002 0006 0004 0001 0002 0003 0004 0005 0006 0007 0008
0008 0010 000f 000e 000d 000c 000b 000a 0009 0009 000a 000b 000c 000d 000e 000f 0010
0008 1234 0abc ffff 0000 8000 7fff 0001 00ff 0000 0001 00ff 0abc 1234 7fff 8000 ffff
0008 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003
0008 0002 0001 0002 0001 0002 0001 0002 0001 0001 0001 0001 0001 0002 0002 0002 0002
0001 00aa 00aa
0002 0200 0100 0100 0200
0003 0033 0011 0022 0011 0022 0033
0004 ffff 0000 ffff 0000 0000 0000 ffff ffff
0005 0050 0040 0030 0020 0010 0010 0020 0030 0040 0050
0006 0601 0605 0603 0602 0606 0604 0601 0602 0603 0604 0605 0606
0007 7007 7001 7006 7002 7005 7003 7004 7001 7002 7003 7004 7005 7006 7007
0001 0000 0000
0003 0000 0005 0000 0000 0000 0005
0008 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0008 ffff ffff ffff ffff ffff ffff ffff ffff ffff ffff ffff ffff ffff ffff ffff ffff
0008 a5a5 5a5a a5a5 5a5a 0f0f f0f0 0f0f f0f0 0f0f 0f0f 5a5a 5a5a a5a5 a5a5 f0f0 f0f0
0008 0001 0002 0003 0004 0005 0006 0007 0008 0001 0002 0003 0004 0005 0006 0007 0008
0008 0008 0007 0006 0005 0004 0003 0002 0001 0001 0002 0003 0004 0005 0006 0007 0008
0002 ffff fffe fffe ffff
0005 4444 1111 3333 1111 2222 1111 1111 2222 3333 4444
0007 0100 0000 0100 0000 0100 0000 ffff 0000 0000 0000 0100 0100 0100 ffff
0006 9000 8000 7000 6000 5000 4000 4000 5000 6000 7000 8000 9000
0008 3c2a 01f9 e7d4 5b60 c013 2288 9e71 6a0d 01f9 2288 3c2a 5b60 6a0d 9e71 c013 e7d4
0004 00c0 00a0 00d0 00b0 00a0 00b0 00c0 00d0
0001 ffff ffff
0008 0004 0004 0001 0001 0009 0009 0000 ffff 0000 0001 0001 0004 0004 0009 0009 ffff
0003 beef dead cafe beef cafe dead
0007 1000 0fff 1001 0ffe 1002 0ffd 1003 0ffd 0ffe 0fff 1000 1001 1002 1003
0008 8001 7ffe 8000 7fff 0002 fffd 0001 fffe 0001 0002 7ffe 7fff 8000 8001 fffd fffe
0002 0000 0000 0000 0000
0006 0063 0021 0047 0005 0099 0038 0005 0021 0038 0047 0063 0099
0005 ffff 0000 8000 0000 ffff 0000 0000 8000 ffff ffff
0008 2b1e 2b1e 0dd7 f002 6e8c 0dd7 a451 4f30 0dd7 0dd7 2b1e 2b1e 4f30 6e8c a451 f002
0000

// ==== verilog.f ====
src/sorter_pkg.sv
src/chunk_collector.sv
src/merge_layer.sv
src/sorted_serializer.sv
src/batcher_sort_top.sv
tests/batcher_sort_assertions.sv
tests/batcher_sort_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the sorter testbench with Verilator, runs it and checks the log for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f verilog.f --top-module batcher_sort_tb \
    --Mdir obj_dir -o batcher_sort_sim

./obj_dir/batcher_sort_sim 2>&1 | tee sim.log

if grep -q "^test passed$" sim.log; then
    exit 0
else
    exit 1
fi
